// File: source/mont_config.svh
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// Operand layout
// Each stored word has WRD_BITS data bits and one carry bit on top
`define MONT_WRD_BITS 8
`define MONT_NUM_WRDS 4   // R = 2^(WRD_BITS*NUM_WRDS) = 2^32

// Modulus
// Odd and below R/4, so a start value below 2P keeps every
// intermediate result below 2P and inside the redundant words
`define MONT_P 32'h3FFF_FFFF

// Negated inverse of P mod R so that P * FACTOR = -1 mod R
`define MONT_FACTOR 32'h4000_0001

// Multiplier latency
// One stage of the squaring sequence per multiply
`define MONT_STAGE_CYCLES 2

// One squaring is SQR + QMUL + RED, so three stages
// First result shows up 3 * MONT_STAGE_CYCLES cycles after start

`endif

// File: source/mont_pkg.sv
`include "mont_config.svh"

package mont_pkg;

  // Redundant operand with word 0 least significant
  // Word i carries weight 2^(WRD_BITS*i) and its top bit is the carry bit
  typedef logic [`MONT_NUM_WRDS-1:0][`MONT_WRD_BITS:0] redun_t;

  typedef struct packed {
    redun_t hi;  // Words NUM_WRDS .. 2*NUM_WRDS-1
    redun_t lo;  // Words 0 .. NUM_WRDS-1
  } prod_half_t;

  // Double width product
  // Squarer fills it word by word and controller reads it as two halves
  typedef union packed {
    logic [2*`MONT_NUM_WRDS-1:0][`MONT_WRD_BITS:0] wrd;
    prod_half_t half;
  } prod_u;

  typedef enum logic [1:0] {
    IDLE,
    SQR,   // T = a * a
    QMUL,  // q = T.lo * FACTOR mod R
    RED    // (T + q * P) / R
  } mont_state_e;

  // Plain integer to redundant form with all carry bits clear
  function automatic redun_t to_redun(
    input logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] val
  );
    redun_t r;
    for (int i = 0; i < `MONT_NUM_WRDS; i++) begin
      r[i] = {1'b0, val[i*`MONT_WRD_BITS +: `MONT_WRD_BITS]};
    end
    return r;
  endfunction

endpackage

// File: source/stage_timer.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module stage_timer (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_clr,
  input  logic [15:0] i_iters,
  input  logic        i_load,
  input  logic        i_dec,
  output logic        o_stage_end,
  output logic        o_last_iter
);

  localparam int cnt_w = ($clog2(`MONT_STAGE_CYCLES) > 0) ? $clog2(`MONT_STAGE_CYCLES) : 1;

  logic [cnt_w-1:0] cnt_q;    // Cycle within the current stage
  logic [15:0]      iters_q;  // Squarings still to finish

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt_q   <= '0;
      iters_q <= '0;
    end else begin
      // Stage counter wraps at the stage length
      if (i_clr || o_stage_end) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end

      if (i_load) begin
        iters_q <= i_iters;  // New run wins over a pending decrement
      end else if (i_dec && (iters_q != 16'd0)) begin
        iters_q <= iters_q - 16'd1;
      end
    end
  end

  assign o_stage_end = (cnt_q == cnt_w'(`MONT_STAGE_CYCLES - 1));
  assign o_last_iter = (iters_q == 16'd1);

endmodule

// File: source/redun_squarer.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module redun_squarer
  import mont_pkg::*;
(
  input  logic   i_clk,
  input  redun_t i_a,
  output prod_u  o_prod
);

  localparam int num_wrds = `MONT_NUM_WRDS;
  localparam int wrd_bits = `MONT_WRD_BITS;
  localparam int prod_w   = 2 * (wrd_bits + 1);             // One word by word product
  localparam int col_w    = prod_w + $clog2(num_wrds);      // Room for a full column

  logic [2*num_wrds-2:0][col_w-1:0] col_c;
  logic [2*num_wrds-2:0][col_w-1:0] col_q;
  logic [prod_w-1:0]                pp;
  logic [col_w:0]                   acc;
  logic [col_w:0]                   carry;
  prod_u                            fold_c;

  // Column sums of all word pairs
  // A square has mirrored cross terms that are taken once and doubled
  always_comb begin
    col_c = '0;
    pp    = '0;
    for (int i = 0; i < num_wrds; i++) begin
      pp            = i_a[i] * i_a[i];
      col_c[2*i]    = col_c[2*i] + pp;
      for (int j = i + 1; j < num_wrds; j++) begin
        pp           = i_a[i] * i_a[j];
        col_c[i+j]   = col_c[i+j] + {pp, 1'b0};  // Cross term counts twice
      end
    end
  end

  always_ff @(posedge i_clk) begin
    col_q <= col_c;
  end

  // Fold column overflow into the next word
  always_comb begin
    carry = '0;
    acc   = '0;
    for (int k = 0; k < 2*num_wrds-1; k++) begin
      acc           = col_q[k] + carry;
      fold_c.wrd[k] = {1'b0, acc[wrd_bits-1:0]};
      carry         = acc >> wrd_bits;
    end
    // What is left lands in the top word, carry bit included
    fold_c.wrd[2*num_wrds-1] = carry[wrd_bits:0];
  end

  // Second register makes the product valid two cycles after i_a
  always_ff @(posedge i_clk) begin
    o_prod <= fold_c;
  end

endmodule

// File: source/half_mul.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module half_mul
  import mont_pkg::*;
(
  input  logic   i_clk,
  input  redun_t i_a,
  input  redun_t i_b,
  input  redun_t i_add,
  input  logic   i_upper,
  output redun_t o_out
);

  localparam int num_wrds = `MONT_NUM_WRDS;
  localparam int wrd_bits = `MONT_WRD_BITS;
  localparam int prod_w   = 2 * (wrd_bits + 1);
  localparam int col_w    = prod_w + $clog2(num_wrds);

  logic [2*num_wrds-2:0][col_w-1:0]    col_c;
  logic [2*num_wrds-2:0][col_w-1:0]    col_q;
  redun_t                              add_q;    // Addend follows its operands
  logic                                upper_q;
  logic [prod_w-1:0]                   pp;
  logic [col_w:0]                      acc;
  logic [col_w:0]                      carry;
  logic [2*num_wrds-1:0][wrd_bits-1:0] full_c;   // Normalized product
  logic [wrd_bits+2:0]                 sum;
  logic [wrd_bits+2:0]                 sum_cy;
  redun_t                              hi_c;
  redun_t                              lo_c;

  always_comb begin
    col_c = '0;
    pp    = '0;
    for (int i = 0; i < num_wrds; i++) begin
      for (int j = 0; j < num_wrds; j++) begin
        pp         = i_a[i] * i_b[j];
        col_c[i+j] = col_c[i+j] + pp;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    col_q   <= col_c;
    add_q   <= i_add;
    upper_q <= i_upper;
  end

  always_comb begin
    carry = '0;
    acc   = '0;
    for (int k = 0; k < 2*num_wrds-1; k++) begin
      acc       = col_q[k] + carry;
      full_c[k] = acc[wrd_bits-1:0];
      carry     = acc >> wrd_bits;
    end
    full_c[2*num_wrds-1] = carry[wrd_bits-1:0];

    // Upper words plus the addend with the last carry in the top carry bit
    sum_cy = '0;
    sum    = '0;
    for (int i = 0; i < num_wrds; i++) begin
      sum     = full_c[num_wrds+i] + add_q[i] + sum_cy;
      hi_c[i] = {1'b0, sum[wrd_bits-1:0]};
      sum_cy  = sum >> wrd_bits;
    end
    hi_c[num_wrds-1][wrd_bits] = sum_cy[0];

    for (int i = 0; i < num_wrds; i++) begin
      lo_c[i] = {1'b0, full_c[i]};
    end
  end

  always_ff @(posedge i_clk) begin
    o_out <= upper_q ? hi_c : lo_c;
  end

endmodule

// File: source/mont_ctrl.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_ctrl
  import mont_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_start,
  input  redun_t i_x,
  input  logic   i_stage_end,
  input  logic   i_last_iter,
  input  prod_u  i_sq_prod,
  input  redun_t i_hm_out,
  output logic   o_tmr_clr,
  output logic   o_iter_load,
  output logic   o_iter_dec,
  output redun_t o_sq_a,
  output redun_t o_hm_a,
  output redun_t o_hm_b,
  output redun_t o_hm_add,
  output logic   o_hm_upper,
  output redun_t o_result,
  output logic   o_val,
  output logic   o_done,
  output logic   o_busy
);

  mont_state_e state_q;
  redun_t      t_hi_q;     // Upper half of T as addend in RED
  logic        t_lo_nz_q;  // T.lo nonzero
  redun_t      q_c;

  assign o_tmr_clr   = i_start;
  assign o_iter_load = i_start;
  assign o_iter_dec  = (state_q == RED) && i_stage_end;
  assign o_busy      = (state_q != IDLE);
  assign o_hm_upper  = (state_q == QMUL);  // Upper half wanted for the RED result

  // Operands go in on the last cycle of the previous stage
  // A fresh start value wins over the fed back result
  assign o_sq_a = i_start ? i_x : i_hm_out;

  always_comb begin
    q_c = i_hm_out;
    q_c[`MONT_NUM_WRDS-1][`MONT_WRD_BITS] = 1'b0;  // Keeps q below R

    // T.lo + q*P is a multiple of R, so it carries exactly one into
    // the upper half unless T.lo is zero
    o_hm_add    = t_hi_q;
    o_hm_add[0] = t_hi_q[0] + {{`MONT_WRD_BITS{1'b0}}, t_lo_nz_q};

    if (state_q == QMUL) begin
      o_hm_a = q_c;
      o_hm_b = to_redun(`MONT_P);
    end else begin
      o_hm_a = i_sq_prod.half.lo;  // Valid in the last SQR cycle
      o_hm_b = to_redun(`MONT_FACTOR);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q  <= IDLE;
      o_result <= '0;
      o_val    <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_val  <= 1'b0;
      o_done <= 1'b0;
      case (state_q)
        SQR: if (i_stage_end) state_q <= QMUL;
        QMUL: if (i_stage_end) state_q <= RED;
        RED: begin
          if (i_stage_end) begin
            o_result <= i_hm_out;
            o_val    <= 1'b1;
            if (i_last_iter) begin
              state_q <= IDLE;
              o_done  <= 1'b1;
            end else begin
              state_q <= SQR;  // Result is already on the squarer input
            end
          end
        end
        default: state_q <= IDLE;
      endcase

      // Restart aborts any run in progress
      if (i_start) begin
        state_q <= SQR;
        o_val   <= 1'b0;
        o_done  <= 1'b0;
      end
    end
  end

  // T captured at the end of SQR
  always_ff @(posedge i_clk) begin
    if ((state_q == SQR) && i_stage_end) begin
      t_hi_q    <= i_sq_prod.half.hi;
      t_lo_nz_q <= |i_sq_prod.half.lo;
    end
  end

endmodule

// File: source/mont_sq_top.sv
`timescale 1ns/1ps

module mont_sq_top
  import mont_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start,
  input  redun_t      i_x,
  input  logic [15:0] i_iters,
  output redun_t      o_result,
  output logic        o_val,
  output logic        o_done,
  output logic        o_busy
);

  // Controller to timer
  logic   tmr_clr;
  logic   iter_load;
  logic   iter_dec;
  logic   stage_end;
  logic   last_iter;

  // Controller to datapath
  redun_t sq_a;
  prod_u  sq_prod;
  redun_t hm_a;
  redun_t hm_b;
  redun_t hm_add;
  logic   hm_upper;
  redun_t hm_out;

  mont_ctrl ctrl_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (i_start),
    .i_x         (i_x),
    .i_stage_end (stage_end),
    .i_last_iter (last_iter),
    .i_sq_prod   (sq_prod),
    .i_hm_out    (hm_out),
    .o_tmr_clr   (tmr_clr),
    .o_iter_load (iter_load),
    .o_iter_dec  (iter_dec),
    .o_sq_a      (sq_a),
    .o_hm_a      (hm_a),
    .o_hm_b      (hm_b),
    .o_hm_add    (hm_add),
    .o_hm_upper  (hm_upper),
    .o_result    (o_result),
    .o_val       (o_val),
    .o_done      (o_done),
    .o_busy      (o_busy)
  );

  stage_timer timer_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_clr       (tmr_clr),
    .i_iters     (i_iters),
    .i_load      (iter_load),
    .i_dec       (iter_dec),
    .o_stage_end (stage_end),
    .o_last_iter (last_iter)
  );

  redun_squarer squarer_i (
    .i_clk  (i_clk),
    .i_a    (sq_a),
    .o_prod (sq_prod)
  );

  half_mul half_mul_i (
    .i_clk   (i_clk),
    .i_a     (hm_a),
    .i_b     (hm_b),
    .i_add   (hm_add),
    .i_upper (hm_upper),
    .o_out   (hm_out)
  );

endmodule

// File: tb/mont_sq_sva.sv
`timescale 1ns/1ps

module mont_sq_sva
  import mont_pkg::*;
(
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_start,
  input mont_state_e i_state,
  input logic        i_val,
  input logic        i_done,
  input logic        i_busy
);

  int fail_cnt = 0;  // Count of failed assertions

  a_val_pulse: assert property (@(posedge i_clk) disable iff (i_rst) i_val |=> !i_val)
    else begin
      $error("o_val stayed high for more than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  a_done_val: assert property (@(posedge i_clk) disable iff (i_rst) i_done |-> i_val)
    else begin
      $error("o_done without o_val");
      fail_cnt = fail_cnt + 1;
    end

  a_done_idle: assert property (@(posedge i_clk) disable iff (i_rst) i_done |-> !i_busy)
    else begin
      $error("o_busy still high with o_done");
      fail_cnt = fail_cnt + 1;
    end

  // A state entered without a restart holds two cycles and then moves on
  a_state_len: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_state != IDLE && i_state != $past(i_state) && !i_start)
      |=> (i_state == $past(i_state)) ##1 (i_state != $past(i_state) || $past(i_start)))
    else begin
      $error("FSM state did not last two cycles");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind mont_ctrl mont_sq_sva sva_i (
  .i_clk   (i_clk),
  .i_rst   (i_rst),
  .i_start (i_start),
  .i_state (state_q),
  .i_val   (o_val),
  .i_done  (o_done),
  .i_busy  (o_busy)
);

// File: tb/mont_sq_tb.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_sq_tb
  import mont_pkg::*;
();

  localparam int max_tests  = 32;
  localparam int rand_cases = 6;
  localparam int max_gap    = 10;
  localparam int sq_cycles  = 3 * `MONT_STAGE_CYCLES;  // SQR, QMUL, RED

  logic        i_clk;
  logic        i_rst;
  logic        i_start;
  redun_t      i_x;
  logic [15:0] i_iters;
  redun_t      o_result;
  logic        o_val;
  logic        o_done;
  logic        o_busy;

  logic [31:0] stim_x     [max_tests];
  logic [15:0] stim_iters [max_tests];
  logic [31:0] stim_first [max_tests];
  logic [31:0] stim_final [max_tests];
  int          num_tests;
  integer      seed = 32'h640b_4951;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          cyc_cnt = 0;
  int          cyc_limit = 0;  // Zero until the stimulus is loaded

  mont_sq_top dut_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_start  (i_start),
    .i_x      (i_x),
    .i_iters  (i_iters),
    .o_result (o_result),
    .o_val    (o_val),
    .o_done   (o_done),
    .o_busy   (o_busy)
  );

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if ((cyc_limit > 0) && (cyc_cnt >= cyc_limit)) begin
      $display("Timeout: the DUT did not finish within %0d cycles", cyc_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // Weighted sum of the redundant words including carry bits
  function automatic logic [63:0] plain_value(input redun_t r);
    logic [63:0] acc;
    acc = '0;
    for (int i = 0; i < `MONT_NUM_WRDS; i++) begin
      acc = acc + (64'(r[i]) << (`MONT_WRD_BITS * i));
    end
    return acc;
  endfunction

  function automatic int case_len(input int idx);
    return sq_cycles * int'(stim_iters[idx]) + 20;
  endfunction

  task automatic check_redun(input string name, input redun_t got, input logic [31:0] exp,
                             input bit exact);
    logic [63:0] val;
    val = plain_value(got);
    if (!exact) begin
      val = val % 64'(`MONT_P);  // Output is only congruent mod P
    end
    checks++;
    if (val !== 64'(exp)) begin
      errors++;
      $display("[FAIL] %s: got %h (value %h), expected %h", name, got, val, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string desc, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %0d %s: FAILED, %0d errors", tests_run, desc, errors - err_before);
    end else begin
      $display("test %0d %s: ok", tests_run, desc);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          iters;
    string       line;
    logic [31:0] x;
    logic [31:0] first;
    logic [31:0] last;
    num_tests = 0;
    fd = $fopen("tb/mont_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tb/mont_stimulus.txt");
    end else begin
      while (!$feof(fd) && (num_tests < max_tests)) begin
        line = "";
        void'($fgets(line, fd));
        if ((line.len() > 0) && (line[0] != "#")) begin
          n = $sscanf(line, "%h %d %h %h", x, iters, first, last);
          if (n == 4) begin
            stim_x[num_tests]     = x;
            stim_iters[num_tests] = iters[15:0];
            stim_first[num_tests] = first;
            stim_final[num_tests] = last;
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Called right after a falling edge and returns one falling edge later
  task automatic drive_start(input logic [31:0] x, input logic [15:0] iters);
    i_start = 1'b1;
    i_x     = to_redun(x);
    i_iters = iters;
    @(negedge i_clk);
    i_start = 1'b0;
    i_x     = '0;
  endtask

  // Optional decoy run aborted after abort_cyc cycles before the real run
  task automatic run_case(input int idx, input int decoy, input int abort_cyc, input int gap);
    int    edge_cnt;
    int    pulses;
    int    err_before;
    bit    finished;
    string desc;
    err_before = errors;
    edge_cnt   = 0;
    pulses     = 0;
    finished   = 1'b0;
    desc = $sformatf("x=%h iters=%0d decoy=%0d abort=%0d gap=%0d", stim_x[idx],
                     stim_iters[idx], decoy, abort_cyc, gap);
    repeat (gap) @(negedge i_clk);
    if (decoy >= 0) begin
      drive_start(stim_x[decoy], stim_iters[decoy]);
      repeat (abort_cyc) @(negedge i_clk);
    end
    drive_start(stim_x[idx], stim_iters[idx]);
    // edge_cnt counts rising edges after the one that sampled i_start
    while (!finished) begin
      check_bit("o_busy", o_busy, !o_done);
      if (o_val) begin
        pulses++;
        check_count("o_val cycle", edge_cnt, sq_cycles * pulses);
        if (pulses == 1) begin
          check_redun("o_result first", o_result, stim_first[idx], 1'b0);
        end
        check_bit("o_done", o_done, pulses == int'(stim_iters[idx]));
        if (o_done || (pulses >= int'(stim_iters[idx]))) begin
          finished = 1'b1;
          check_redun("o_result final", o_result, stim_final[idx], 1'b0);
          check_count("o_val pulses", pulses, int'(stim_iters[idx]));
        end
      end
      if (!finished) begin
        @(negedge i_clk);
        edge_cnt++;
      end
    end
    @(negedge i_clk);
    check_bit("o_val after done", o_val, 1'b0);
    check_bit("o_busy after done", o_busy, 1'b0);
    finish_test(desc, err_before);
  endtask

  initial begin
    int budget;
    int gap;
    int abort_cyc;
    int decoy;
    int err_before;
    int total_err;
    i_clk   = 1'b0;
    i_rst   = 1'b1;
    i_start = 1'b0;
    i_x     = '0;
    i_iters = 16'd0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_stimulus();

    if (num_tests < rand_cases) begin
      $display("Only %0d tests read from tb/mont_stimulus.txt, %0d needed", num_tests,
               rand_cases);
      $display("Simulation failed");
    end else begin
      // Budget covers plain runs, one restart and the random restarts in full
      budget = 10 + case_len(4) + case_len(5);
      for (int i = 0; i < num_tests; i++) begin
        budget += case_len(i);
      end
      for (int k = 0; k < rand_cases; k++) begin
        budget += case_len(k) + case_len((k + 3) % num_tests) + max_gap;
      end
      cyc_limit = 2 * budget;

      err_before = errors;
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      check_bit("o_val", o_val, 1'b0);
      check_bit("o_done", o_done, 1'b0);
      check_bit("o_busy", o_busy, 1'b0);
      check_redun("o_result", o_result, 32'h0, 1'b1);
      i_rst = 1'b0;
      @(negedge i_clk);
      check_bit("o_busy idle", o_busy, 1'b0);
      finish_test("reset values", err_before);

      for (int i = 0; i < num_tests; i++) begin
        run_case(i, -1, 0, 1);
      end

      run_case(5, 4, 17, 2);  // Restart on the edge of the 3rd decoy result

      for (int k = 0; k < rand_cases; k++) begin
        gap       = $unsigned($random(seed)) % max_gap;
        decoy     = (k + 3) % num_tests;
        abort_cyc = $unsigned($random(seed)) % (sq_cycles * int'(stim_iters[decoy]));
        run_case(k, decoy, abort_cyc, gap);
      end

      total_err = errors + dut_i.ctrl_i.sva_i.fail_cnt;
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, checks, errors, dut_i.ctrl_i.sva_i.fail_cnt);
      if (total_err == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
    end
    $finish;
  end

endmodule

// File: tb/mont_stimulus.txt
# columns: start value (hex), iteration count (decimal),
# expected first result mod P (hex), expected final result mod P (hex)
00000001 1 10000000 10000000
00000001 4 10000000 00000001
00000002 6 00000001 10000000
00000400 7 00040000 00000040
20000000 10 04000000 00100000
00000003 3 10000002 19a10000
00000005 2 10000006 31000009
00010001 1 10008001 10008001
000000ff 1 10003f80 10003f80
0000ffff 1 0fff8001 0fff8001
7ffffffd 3 10000000 00010000
3ffffffe 2 10000000 01000000
00000000 3 00000000 00000000
3fffffff 2 00000000 00000000
40000000 5 10000000 10000000

// File: project.f
+incdir+source
source/mont_pkg.sv
source/stage_timer.sv
source/redun_squarer.sv
source/half_mul.sv
source/mont_ctrl.sv
source/mont_sq_top.sv
tb/mont_sq_sva.sv
tb/mont_sq_tb.sv

// File: Bender.yml
package:
  name: mont_sq

sources:
  - include_dirs:
      - source
    files:
      - source/mont_pkg.sv
      - source/stage_timer.sv
      - source/redun_squarer.sv
      - source/half_mul.sv
      - source/mont_ctrl.sv
      - source/mont_sq_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/mont_sq_sva.sv
      - tb/mont_sq_tb.sv
